//--- Makefile
# Verilator build of the back end testbench, run from the project root

TOP = tb_ooo_backend

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f ooo_backend.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

//--- hw/alu_unit.sv
/*
  One-cycle integer unit with one result slot.
  The result is ready on the cycle after issue and stays until grant.
  Issue must only come while available is high. The unit does not check it.
*/
`timescale 1ns/1ps

module alu_unit (
	input  logic				clock,			// system clock
	input  logic				rst_n,			// async reset, active low
	input  logic				issue,			// start an operation this cycle
	input  ooo_pkg::alu_func_t	func,			// operation select
	input  ooo_pkg::word_t		opa,			// first operand
	input  ooo_pkg::word_t		opb,			// second operand
	input  ooo_pkg::rob_idx_t	rob_idx,		// owner entry in the rob
	input  logic				grant,			// bus took the held result
	output logic				available,		// can accept an issue now
	output logic				result_ready,	// slot holds a finished result
	output ooo_pkg::word_t		result_value,	// held result
	output ooo_pkg::rob_idx_t	result_rob_idx	// owner of the held result
);

ooo_pkg::word_t alu_out;		// combinational result of this cycle's issue

////////////////////////////////////////////////////////////////////////////
// operation
////////////////////////////////////////////////////////////////////////////
always_comb begin
	case (func)
		ooo_pkg::ALU_ADD: alu_out = opa + opb;		// add
		ooo_pkg::ALU_SUB: alu_out = opa - opb;		// subtract
		ooo_pkg::ALU_AND: alu_out = opa & opb;		// and
		default:          alu_out = opa ^ opb;		// xor
	endcase
end

////////////////////////////////////////////////////////////////////////////
// holding slot
////////////////////////////////////////////////////////////////////////////
// free now, or emptied by the grant at this edge
assign available = ~result_ready | grant;

always_ff @(posedge clock or negedge rst_n) begin
	if (!rst_n) begin
		result_ready <= 1'b0;
	end else if (issue) begin
		result_ready <= 1'b1;		// new result replaces a granted one
	end else if (grant) begin
		result_ready <= 1'b0;		// bus took it, slot empty
	end
end

always_ff @(posedge clock) begin
	if (issue) begin
		result_value   <= alu_out;
		result_rob_idx <= rob_idx;	// tag travels with the value
	end
end

endmodule

//--- hw/cdb_arbiter.sv
/*
  Common data bus arbiter, one result per cycle.
  Fixed priority with the multiplier over the ALU. Purely combinational.
  A unit that loses holds its result and asks again next cycle.
*/
`timescale 1ns/1ps

module cdb_arbiter (
	input  logic				alu_result_ready,		// ALU has a result
	input  ooo_pkg::word_t		alu_result_value,
	input  ooo_pkg::rob_idx_t	alu_result_rob_idx,
	input  logic				mult_result_ready,		// multiplier has a result
	input  ooo_pkg::word_t		mult_result_value,
	input  ooo_pkg::rob_idx_t	mult_result_rob_idx,
	output logic				alu_grant,				// ALU result goes on the bus
	output logic				mult_grant,				// multiplier result goes on the bus
	output logic				cdb_valid,				// bus carries a result
	output ooo_pkg::word_t		cdb_value,
	output ooo_pkg::rob_idx_t	cdb_rob_idx
);

////////////////////////////////////////////////////////////////////////////
// grants
////////////////////////////////////////////////////////////////////////////
assign mult_grant = mult_result_ready;							// multiplier first
assign alu_grant  = alu_result_ready & ~mult_result_ready;		// ALU only when bus free

assign cdb_valid = mult_result_ready | alu_result_ready;

// result mux, follows the grant
always_comb begin
	if (mult_grant) begin
		cdb_value   = mult_result_value;
		cdb_rob_idx = mult_result_rob_idx;
	end else begin
		cdb_value   = alu_result_value;		// don't care when nothing is valid
		cdb_rob_idx = alu_result_rob_idx;
	end
end

endmodule

//--- hw/mult_unit.sv
/*
  Pipelined multiplier, lower XLEN bits of opa * opb.
  Each stage adds the partial product of one slice of opb.
  The result is ready MULT_STAGES cycles after issue when nothing stalls.
  A waiting result in the last stage freezes every stage, and
  available is low during that time.
*/
`timescale 1ns/1ps
`include "ooo_backend_macros.svh"

module mult_unit (
	input  logic				clock,			// system clock
	input  logic				rst_n,			// async reset, active low
	input  logic				issue,			// start a multiply this cycle
	input  ooo_pkg::word_t		opa,			// multiplicand
	input  ooo_pkg::word_t		opb,			// multiplier
	input  ooo_pkg::rob_idx_t	rob_idx,		// owner entry in the rob
	input  logic				grant,			// bus took the last stage
	output logic				available,		// pipe is moving
	output logic				result_ready,	// last stage holds a product
	output ooo_pkg::word_t		result_value,	// lower product bits
	output ooo_pkg::rob_idx_t	result_rob_idx	// owner of the product
);

localparam int LAST  = `MULT_STAGES - 1;							// index of the output stage
localparam int CHUNK = (`XLEN + `MULT_STAGES - 1) / `MULT_STAGES;	// opb bits per stage
localparam ooo_pkg::word_t CHUNK_MASK = (ooo_pkg::word_t'(1) << CHUNK) - 1;

logic [`MULT_STAGES-1:0]	stg_valid;					// stage holds a multiply
ooo_pkg::word_t				stg_sum [`MULT_STAGES];		// running partial sum
ooo_pkg::rob_idx_t			stg_rob [`MULT_STAGES];		// rob tag per stage
ooo_pkg::word_t				stg_opa [`MULT_STAGES-1];	// operands still needed
ooo_pkg::word_t				stg_opb [`MULT_STAGES-1];
logic						stall;						// output stage not taken

// slice k of b times a, moved to its weight
function automatic ooo_pkg::word_t partial(input ooo_pkg::word_t a,
		input ooo_pkg::word_t b, input int k);
	ooo_pkg::word_t slice;
	slice = (b >> (k * CHUNK)) & CHUNK_MASK;
	return (a * slice) << (k * CHUNK);
endfunction

assign stall     = stg_valid[LAST] & ~grant;
assign available = ~stall;

////////////////////////////////////////////////////////////////////////////
// pipeline
////////////////////////////////////////////////////////////////////////////
always_ff @(posedge clock or negedge rst_n) begin
	if (!rst_n) begin
		stg_valid <= '0;
	end else if (!stall) begin
		stg_valid <= {stg_valid[LAST-1:0], issue};	// shift one stage per cycle
	end
end

always_ff @(posedge clock) begin
	if (!stall) begin
		stg_sum[0] <= partial(opa, opb, 0);		// lowest slice first
		stg_rob[0] <= rob_idx;
		stg_opa[0] <= opa;
		stg_opb[0] <= opb;
		for (int i = 1; i < `MULT_STAGES; i++) begin
			stg_sum[i] <= stg_sum[i-1] + partial(stg_opa[i-1], stg_opb[i-1], i);
			stg_rob[i] <= stg_rob[i-1];
		end
		for (int i = 1; i < LAST; i++) begin
			stg_opa[i] <= stg_opa[i-1];			// operands end one stage early
			stg_opb[i] <= stg_opb[i-1];
		end
	end
end

assign result_ready   = stg_valid[LAST];
assign result_value   = stg_sum[LAST];
assign result_rob_idx = stg_rob[LAST];

endmodule

//--- hw/ooo_backend.sv
/*
  Top of the execution back end.
  Operands arrive resolved at dispatch. Commit has no back-pressure.
  Holds the reorder buffer, both units and the bus arbiter.
*/
`timescale 1ns/1ps

module ooo_backend (
	input  logic					clock,				// system clock
	input  logic					rst_n,				// async reset, active low
	input  logic					dispatch_valid,
	input  ooo_pkg::fu_select_t		dispatch_fu,
	input  ooo_pkg::alu_func_t		dispatch_func,
	input  ooo_pkg::word_t			dispatch_opa,
	input  ooo_pkg::word_t			dispatch_opb,
	input  ooo_pkg::arf_idx_t		dispatch_dest,
	output logic					dispatch_ready,
	output logic					commit_valid,
	output ooo_pkg::rob_idx_t		commit_rob_idx,
	output ooo_pkg::arf_idx_t		commit_dest,
	output ooo_pkg::word_t			commit_value,
	output logic					commit_wr_en
);

// rob to units
logic				alu_issue;
logic				mult_issue;
ooo_pkg::alu_func_t	issue_func;
ooo_pkg::word_t		issue_opa;
ooo_pkg::word_t		issue_opb;
ooo_pkg::rob_idx_t	issue_rob_idx;
// units to rob
logic				alu_available;
logic				mult_available;
// units to arbiter
logic				alu_result_ready;
ooo_pkg::word_t		alu_result_value;
ooo_pkg::rob_idx_t	alu_result_rob_idx;
logic				mult_result_ready;
ooo_pkg::word_t		mult_result_value;
ooo_pkg::rob_idx_t	mult_result_rob_idx;
logic				alu_grant;
logic				mult_grant;
// bus to rob
logic				cdb_valid;
ooo_pkg::word_t		cdb_value;
ooo_pkg::rob_idx_t	cdb_rob_idx;

////////////////////////////////////////////////////////////////////////////
// reorder buffer
////////////////////////////////////////////////////////////////////////////
reorder_buffer rob (
	.clock(clock), .rst_n(rst_n),
	.dispatch_valid(dispatch_valid), .dispatch_fu(dispatch_fu),
	.dispatch_func(dispatch_func), .dispatch_opa(dispatch_opa),
	.dispatch_opb(dispatch_opb), .dispatch_dest(dispatch_dest),
	.dispatch_ready(dispatch_ready),
	.alu_available(alu_available), .mult_available(mult_available),
	.alu_issue(alu_issue), .mult_issue(mult_issue), .issue_func(issue_func),
	.issue_opa(issue_opa), .issue_opb(issue_opb), .issue_rob_idx(issue_rob_idx),
	.cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx), .cdb_value(cdb_value),
	.commit_valid(commit_valid), .commit_rob_idx(commit_rob_idx),
	.commit_dest(commit_dest), .commit_value(commit_value),
	.commit_wr_en(commit_wr_en)
);

////////////////////////////////////////////////////////////////////////////
// functional units
////////////////////////////////////////////////////////////////////////////
alu_unit alu (
	.clock(clock), .rst_n(rst_n), .issue(alu_issue), .func(issue_func),
	.opa(issue_opa), .opb(issue_opb), .rob_idx(issue_rob_idx), .grant(alu_grant),
	.available(alu_available), .result_ready(alu_result_ready),
	.result_value(alu_result_value), .result_rob_idx(alu_result_rob_idx)
);

mult_unit mult (
	.clock(clock), .rst_n(rst_n), .issue(mult_issue),
	.opa(issue_opa), .opb(issue_opb), .rob_idx(issue_rob_idx), .grant(mult_grant),
	.available(mult_available), .result_ready(mult_result_ready),
	.result_value(mult_result_value), .result_rob_idx(mult_result_rob_idx)
);

////////////////////////////////////////////////////////////////////////////
// result bus
////////////////////////////////////////////////////////////////////////////
cdb_arbiter cdb (
	.alu_result_ready(alu_result_ready), .alu_result_value(alu_result_value),
	.alu_result_rob_idx(alu_result_rob_idx),
	.mult_result_ready(mult_result_ready), .mult_result_value(mult_result_value),
	.mult_result_rob_idx(mult_result_rob_idx),
	.alu_grant(alu_grant), .mult_grant(mult_grant),
	.cdb_valid(cdb_valid), .cdb_value(cdb_value), .cdb_rob_idx(cdb_rob_idx)
);

endmodule

//--- hw/ooo_backend_macros.svh
/*
  Sizes of the execution back end.
  ROB_SIZE must be a power of two because the pointers wrap by overflow.
  MULT_STAGES must be at least 2.
  ZERO_REG is never written at commit.
*/
`ifndef OOO_BACKEND_MACROS_SVH
`define OOO_BACKEND_MACROS_SVH

// data path
`define XLEN		64		// operand and result width

// reorder buffer
`define ROB_SIZE	8		// entries, power of two

// architectural registers
`define ARF_SIZE	32		// register count
`define ZERO_REG	31		// hardwired zero, commits with no write

// multiplier
`define MULT_STAGES	3		// registered stages, issue to result

`endif

//--- hw/ooo_pkg.sv
/*
  Shared types of the back end.
  Widths follow the sizes in ooo_backend_macros.svh.
  rob_idx_t carries no wrap bit. The reorder buffer keeps that bit inside.
*/
`include "ooo_backend_macros.svh"

package ooo_pkg;

	// operand or result word
	typedef logic [`XLEN-1:0] word_t;

	// architectural register number
	typedef logic [$clog2(`ARF_SIZE)-1:0] arf_idx_t;

	// slot in the reorder buffer
	typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

	// integer unit operations
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,		// opa + opb
		ALU_SUB = 2'b01,		// opa - opb
		ALU_AND = 2'b10,		// bitwise and
		ALU_XOR = 2'b11			// bitwise xor
	} alu_func_t;

	// which unit gets the operation
	typedef enum logic {
		FU_ALU  = 1'b0,			// one-cycle integer unit
		FU_MULT = 1'b1			// pipelined multiplier
	} fu_select_t;

endpackage

//--- hw/reorder_buffer.sv
/*
  Reorder buffer for the execution back end.
  Entries are allocated at dispatch in program order and steered to a unit.
  Bus results mark an entry done. The head commits one entry per cycle
  once done, earliest the cycle after its bus write.
  The commit side always accepts. ROB_SIZE must be a power of two.
*/
`timescale 1ns/1ps
`include "ooo_backend_macros.svh"

module reorder_buffer (
	input  logic					clock,				// system clock
	input  logic					rst_n,				// async reset, active low
	// dispatch
	input  logic					dispatch_valid,		// operation offered
	input  ooo_pkg::fu_select_t		dispatch_fu,		// target unit
	input  ooo_pkg::alu_func_t		dispatch_func,		// ALU operation
	input  ooo_pkg::word_t			dispatch_opa,		// resolved operands
	input  ooo_pkg::word_t			dispatch_opb,
	input  ooo_pkg::arf_idx_t		dispatch_dest,		// architectural destination
	output logic					dispatch_ready,		// operation can be taken
	// unit status
	input  logic					alu_available,
	input  logic					mult_available,
	// issue
	output logic					alu_issue,			// one-cycle strobes
	output logic					mult_issue,
	output ooo_pkg::alu_func_t		issue_func,
	output ooo_pkg::word_t			issue_opa,
	output ooo_pkg::word_t			issue_opb,
	output ooo_pkg::rob_idx_t		issue_rob_idx,		// allocated entry
	// result bus
	input  logic					cdb_valid,
	input  ooo_pkg::rob_idx_t		cdb_rob_idx,
	input  ooo_pkg::word_t			cdb_value,
	// commit
	output logic					commit_valid,		// head retires this cycle
	output ooo_pkg::rob_idx_t		commit_rob_idx,
	output ooo_pkg::arf_idx_t		commit_dest,
	output ooo_pkg::word_t			commit_value,
	output logic					commit_wr_en		// write unless zero reg
);

localparam int PTR_W = $clog2(`ROB_SIZE);		// index bits, one more for wrap

logic [PTR_W:0]			head;						// oldest entry plus wrap bit
logic [PTR_W:0]			tail;						// next free entry plus wrap bit
ooo_pkg::rob_idx_t		head_idx;
ooo_pkg::rob_idx_t		tail_idx;
logic					full;
logic					empty;
logic					unit_free;					// chosen unit can take it
logic					accept;						// dispatch handshake
logic [`ROB_SIZE-1:0]	done;						// result written back
ooo_pkg::arf_idx_t		ent_dest  [`ROB_SIZE];		// destination per entry
ooo_pkg::word_t			ent_value [`ROB_SIZE];		// result per entry

assign head_idx = head[PTR_W-1:0];
assign tail_idx = tail[PTR_W-1:0];
assign empty    = (head == tail);
assign full     = (head[PTR_W] != tail[PTR_W]) && (head_idx == tail_idx);	// wrapped once

////////////////////////////////////////////////////////////////////////////
// dispatch and issue
////////////////////////////////////////////////////////////////////////////
assign unit_free = (dispatch_fu == ooo_pkg::FU_MULT) ? mult_available : alu_available;

assign dispatch_ready = ~full & unit_free;
assign accept         = dispatch_valid & dispatch_ready;

assign alu_issue     = accept & (dispatch_fu == ooo_pkg::FU_ALU);
assign mult_issue    = accept & (dispatch_fu == ooo_pkg::FU_MULT);
assign issue_func    = dispatch_func;				// multiplier ignores it
assign issue_opa     = dispatch_opa;
assign issue_opb     = dispatch_opb;
assign issue_rob_idx = tail_idx;					// entry allocated this edge

////////////////////////////////////////////////////////////////////////////
// commit
////////////////////////////////////////////////////////////////////////////
assign commit_valid   = ~empty & done[head_idx];
assign commit_rob_idx = head_idx;
assign commit_dest    = ent_dest[head_idx];
assign commit_value   = ent_value[head_idx];
assign commit_wr_en   = commit_valid && (commit_dest != ooo_pkg::arf_idx_t'(`ZERO_REG));

////////////////////////////////////////////////////////////////////////////
// pointers and done flags
////////////////////////////////////////////////////////////////////////////
always_ff @(posedge clock or negedge rst_n) begin
	if (!rst_n) begin
		head <= '0;
		tail <= '0;
		done <= '0;
	end else begin
		if (accept) begin
			tail           <= tail + 1'b1;			// wraps through the extra bit
			done[tail_idx] <= 1'b0;					// new entry waits for its result
		end
		if (cdb_valid) begin
			done[cdb_rob_idx] <= 1'b1;				// never the entry being allocated
		end
		if (commit_valid) begin
			head <= head + 1'b1;					// retire in order
		end
	end
end

// entry payload
always_ff @(posedge clock) begin
	if (accept) begin
		ent_dest[tail_idx] <= dispatch_dest;
	end
	if (cdb_valid) begin
		ent_value[cdb_rob_idx] <= cdb_value;		// result lands by rob tag
	end
end

endmodule

//--- ooo_backend.f
+incdir+hw
hw/ooo_pkg.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/cdb_arbiter.sv
hw/reorder_buffer.sv
hw/ooo_backend.sv
tests/tb_ooo_backend.sv

//--- tests/tb_ooo_backend.sv
/*
  Testbench for the execution back end, random mixed ALU and multiply traffic.
  Stimulus from a 32-bit Galois LFSR, seed 97, one step per bit taken.
  Expected results come from a queue model filled at each accepted dispatch.
  Inputs change on the falling edge, commit outputs are sampled there too.
*/
`timescale 1ns/1ps
`include "ooo_backend_macros.svh"

module tb_ooo_backend;

localparam int N_MIX      = 200;							// ops with random gaps
localparam int N_BURST    = 120;							// ops with valid held high
localparam int MAX_CYCLES = 40 * (N_MIX + N_BURST) + 100;	// watchdog limit

logic					clock;
logic					rst_n;
logic					dispatch_valid;
ooo_pkg::fu_select_t	dispatch_fu;
ooo_pkg::alu_func_t		dispatch_func;
ooo_pkg::word_t			dispatch_opa;
ooo_pkg::word_t			dispatch_opb;
ooo_pkg::arf_idx_t		dispatch_dest;
logic					dispatch_ready;
logic					commit_valid;
ooo_pkg::rob_idx_t		commit_rob_idx;
ooo_pkg::arf_idx_t		commit_dest;
ooo_pkg::word_t			commit_value;
logic					commit_wr_en;

logic [31:0]			lfsr = 32'd97;		// random state
logic					took = 1'b0;		// offer accepted at the last edge
int						accepted = 0;		// dispatch handshakes seen
int						committed = 0;		// commits checked
int						checks = 0;
int						errors = 0;
int						cycles = 0;
int						max_occ = 0;		// peak outstanding ops
ooo_pkg::word_t			exp_value [$];		// model queue, program order
ooo_pkg::arf_idx_t		exp_dest  [$];
ooo_pkg::rob_idx_t		exp_rob   [$];

ooo_backend UUT (
	.clock(clock), .rst_n(rst_n),
	.dispatch_valid(dispatch_valid), .dispatch_fu(dispatch_fu),
	.dispatch_func(dispatch_func), .dispatch_opa(dispatch_opa),
	.dispatch_opb(dispatch_opb), .dispatch_dest(dispatch_dest),
	.dispatch_ready(dispatch_ready),
	.commit_valid(commit_valid), .commit_rob_idx(commit_rob_idx),
	.commit_dest(commit_dest), .commit_value(commit_value),
	.commit_wr_en(commit_wr_en)
);

initial begin
	clock = 1'b0;
	forever #4 clock = ~clock;		// 8 ns period
end

////////////////////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////////////////////
// x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h8020_0003;
	end
	return s >> 1;
endfunction

task automatic draw(input int n, output logic [63:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		v    = {v[62:0], lfsr[0]};		// one step per bit
		lfsr = lfsr_step(lfsr);
	end
endtask

// result by the operation rules
function automatic ooo_pkg::word_t model_result(input ooo_pkg::fu_select_t fu,
		input ooo_pkg::alu_func_t func, input ooo_pkg::word_t a, input ooo_pkg::word_t b);
	if (fu == ooo_pkg::FU_MULT) begin
		return a * b;		// 64-bit product keeps the low word
	end
	case (func)
		ooo_pkg::ALU_ADD: return a + b;
		ooo_pkg::ALU_SUB: return a - b;
		ooo_pkg::ALU_AND: return a & b;
		default:          return a ^ b;
	endcase
endfunction

task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
	checks++;
	assert (got == exp) else begin
		$display("[ERROR] %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic report(input string name, input int ops, input int err_before);
	$display("test %-12s %0d ops, %0d errors, peak occupancy %0d",
		name, ops, errors - err_before, max_occ);
endtask

// offer one random op after gap idle cycles, return once it is taken
task automatic send_op(input int gap);
	logic [63:0] r;
	if (gap > 0) begin
		dispatch_valid = 1'b0;
		repeat (gap) @(negedge clock);
	end
	draw(1, r);
	dispatch_fu = ooo_pkg::fu_select_t'(r[0]);
	draw(2, r);
	dispatch_func = ooo_pkg::alu_func_t'(r[1:0]);
	draw(64, r);
	dispatch_opa = r;
	draw(64, r);
	dispatch_opb = r;
	draw(5, r);
	dispatch_dest = r[4:0];
	dispatch_valid = 1'b1;
	do @(negedge clock); while (!took);		// fields held while refused
endtask

task automatic drain();
	dispatch_valid = 1'b0;
	while (committed != accepted) @(negedge clock);
endtask

////////////////////////////////////////////////////////////////////////////
// monitors
////////////////////////////////////////////////////////////////////////////
// handshake sampled like a flop, model entry pushed in program order
always @(posedge clock) begin
	if (rst_n && dispatch_valid && dispatch_ready) begin
		exp_value.push_back(model_result(dispatch_fu, dispatch_func,
			dispatch_opa, dispatch_opb));
		exp_dest.push_back(dispatch_dest);
		exp_rob.push_back(ooo_pkg::rob_idx_t'(accepted % `ROB_SIZE));
		accepted++;
	end
	took <= rst_n && dispatch_valid && dispatch_ready;
end

// commit outputs are stable mid cycle, one commit per high cycle
always @(negedge clock) begin
	// entries held now, the head on the commit port included
	if (accepted - committed > max_occ) begin
		max_occ = accepted - committed;
	end
	checks++;
	assert (accepted - committed <= `ROB_SIZE) else begin
		$display("more than %0d operations outstanding", `ROB_SIZE);
		errors++;
	end
	if (rst_n && commit_valid) begin
		checks++;
		assert (exp_value.size() != 0) else begin
			$display("commit seen with no operation outstanding");
			errors++;
		end
		if (exp_value.size() != 0) begin
			check_eq("commit_rob_idx", commit_rob_idx, exp_rob.pop_front());
			check_eq("commit_dest", commit_dest, exp_dest[0]);
			check_eq("commit_wr_en", commit_wr_en, exp_dest[0] != `ZERO_REG);
			check_eq("commit_value", commit_value, exp_value.pop_front());
			void'(exp_dest.pop_front());
		end
		committed++;
	end
end

initial begin
	while (cycles < MAX_CYCLES) begin
		@(posedge clock);
		cycles++;
	end
	$display("timeout after %0d cycles, %0d operations not committed",
		cycles, accepted - committed);
	$display("TB FAILED");
	$finish;
end

////////////////////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////////////////////
initial begin
	int err0;
	logic [63:0] r;
	rst_n          = 1'b0;
	dispatch_valid = 1'b0;
	dispatch_fu    = ooo_pkg::FU_ALU;
	dispatch_func  = ooo_pkg::ALU_ADD;
	dispatch_opa   = '0;
	dispatch_opb   = '0;
	dispatch_dest  = '0;
	repeat (2) @(posedge clock);		// two rising edges in reset
	@(negedge clock);
	rst_n = 1'b1;

	err0 = errors;
	repeat (3) begin
		@(negedge clock);
		check_eq("commit_valid", commit_valid, 1'b0);
		check_eq("dispatch_ready", dispatch_ready, 1'b1);
	end
	report("reset_state", 0, err0);

	err0 = errors;
	for (int i = 0; i < N_MIX; i++) begin
		draw(2, r);
		send_op(int'(r[1:0]));		// 0 to 3 idle cycles
	end
	drain();
	report("random_mix", N_MIX, err0);

	err0 = errors;
	for (int i = 0; i < N_BURST; i++) begin
		send_op(0);
	end
	drain();
	report("burst", N_BURST, err0);

	err0 = errors;
	repeat (5) @(negedge clock);		// a stray commit would show here
	check_eq("committed", committed, accepted);
	check_eq("model queue size", exp_value.size(), 0);
	report("drain", accepted, err0);

	$display("checks %0d, errors %0d, dispatched %0d, committed %0d",
		checks, errors, accepted, committed);
	if (errors == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

endmodule
